// File: axi_pkg.sv
package axi_pkg;

  localparam int axi_id_bits   = 4;
  localparam int axi_ids_bits  = axi_id_bits + 1;  // Master tag on top
  localparam int axi_addr_bits = 32;
  localparam int axi_data_bits = 32;
  localparam int axi_len_bits  = 8;
  localparam int axi_size_bits = 3;

  localparam logic master_0_id = 1'b0;
  localparam logic master_1_id = 1'b1;

  localparam logic [1:0] burst_fixed = 2'b00;
  localparam logic [1:0] burst_incr  = 2'b01;
  localparam logic [1:0] burst_wrap  = 2'b10;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_decerr = 2'b11;

  typedef struct packed {
    logic [axi_id_bits-1:0]   id;
    logic [axi_addr_bits-1:0] addr;
    logic [axi_len_bits-1:0]  len;
    logic [axi_size_bits-1:0] size;
    logic [1:0]               burst;
  } ar_m_t;

  // Slave side, ID carries the master tag
  typedef struct packed {
    logic [axi_ids_bits-1:0]  id;
    logic [axi_addr_bits-1:0] addr;
    logic [axi_len_bits-1:0]  len;
    logic [axi_size_bits-1:0] size;
    logic [1:0]               burst;
  } ar_s_t;

  typedef struct packed {
    logic [axi_ids_bits-1:0]  id;
    logic [axi_data_bits-1:0] data;
    logic [1:0]               resp;
    logic                     last;
  } r_s_t;

  typedef struct packed {
    logic [axi_id_bits-1:0]   id;
    logic [axi_data_bits-1:0] data;
    logic [1:0]               resp;
    logic                     last;
  } r_m_t;

endpackage

// File: addr_map_pkg.sv
package addr_map_pkg;

  typedef enum logic [1:0] {
    slave_0,
    slave_1,
    slave_def
  } slave_sel_e;

  localparam int n_slaves = 3;

  // Two 64 KB windows, everything else is unmapped
  localparam logic [axi_pkg::axi_addr_bits-1:0] slave0_base    = 32'h0000_0000;
  localparam logic [axi_pkg::axi_addr_bits-1:0] slave1_base    = 32'h1000_0000;
  localparam logic [axi_pkg::axi_addr_bits-1:0] slave_win_mask = 32'hffff_0000;

  function automatic slave_sel_e addr_decode(
    input logic [axi_pkg::axi_addr_bits-1:0] addr
  );
    slave_sel_e sel;
    if ((addr & slave_win_mask) == slave0_base) begin
      sel = slave_0;
    end else if ((addr & slave_win_mask) == slave1_base) begin
      sel = slave_1;
    end else begin
      sel = slave_def;  // DECERR
    end
    return sel;
  endfunction

endpackage

// File: ar_router.sv
`timescale 1ns/1ps

module ar_router (
  input  logic                              clk,
  input  logic                              rstn,
  input  axi_pkg::ar_m_t                    m0_ar,
  input  logic                              m0_arvalid,
  output logic                              m0_arready,
  input  logic                              m0_rdone,
  input  axi_pkg::ar_m_t                    m1_ar,
  input  logic                              m1_arvalid,
  output logic                              m1_arready,
  input  logic                              m1_rdone,
  output axi_pkg::ar_s_t                    s_ar [addr_map_pkg::n_slaves],
  output logic [addr_map_pkg::n_slaves-1:0] s_arvalid,
  input  logic [addr_map_pkg::n_slaves-1:0] s_arready,
  input  logic [addr_map_pkg::n_slaves-1:0] s_rdone
);
  import axi_pkg::*;
  import addr_map_pkg::*;

  typedef enum logic [1:0] {
    grant_free,
    grant_m0,
    grant_m1
  } grant_e;

  grant_e              grant_q;
  grant_e              grant_d;
  grant_e              owner;
  ar_s_t               ar_sel;
  slave_sel_e          sel;
  logic                valid_sel;
  logic                ready_sel;
  logic                blocked;
  logic                hs;
  logic [1:0]          m_lock;  // One burst in flight per master
  logic [n_slaves-1:0] s_lock;  // One burst in flight per slave

  // While free the grant follows the valids directly
  always_comb begin
    owner = grant_q;
    if (grant_q == grant_free) begin
      if (m0_arvalid) begin
        owner = grant_m0;  // M0 first
      end else if (m1_arvalid) begin
        owner = grant_m1;
      end
    end
  end

  always_comb begin
    ar_sel    = '0;
    valid_sel = 1'b0;
    blocked   = 1'b1;
    case (owner)
      grant_m0: begin
        ar_sel    = ar_s_t'({master_0_id, m0_ar});  // Tag lands above the ID
        valid_sel = m0_arvalid;
        blocked   = m_lock[0];
      end
      grant_m1: begin
        ar_sel    = ar_s_t'({master_1_id, m1_ar});
        valid_sel = m1_arvalid;
        blocked   = m_lock[1];
      end
      default: ;
    endcase
  end

  assign sel       = addr_decode(ar_sel.addr);
  assign ready_sel = s_arready[sel] & ~blocked & ~s_lock[sel];
  assign hs        = valid_sel & ready_sel;

  // Decoder, unselected slaves see zeros
  always_comb begin
    for (int i = 0; i < n_slaves; i++) begin
      s_ar[i]      = '0;
      s_arvalid[i] = 1'b0;
    end
    s_ar[sel]      = ar_sel;
    s_arvalid[sel] = valid_sel & ~blocked & ~s_lock[sel];
  end

  assign m0_arready = (owner == grant_m0) & ready_sel;
  assign m1_arready = (owner == grant_m1) & ready_sel;

  // Grant drops once the slave takes the request
  assign grant_d = hs ? grant_free : owner;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      grant_q <= grant_free;
      m_lock  <= '0;
      s_lock  <= '0;
    end else begin
      grant_q   <= grant_d;
      m_lock[0] <= m_lock[0] ? ~m0_rdone : (m0_arvalid & m0_arready);
      m_lock[1] <= m_lock[1] ? ~m1_rdone : (m1_arvalid & m1_arready);
      for (int i = 0; i < n_slaves; i++) begin
        s_lock[i] <= s_lock[i] ? ~s_rdone[i] : (s_arvalid[i] & s_arready[i]);
      end
    end
  end

endmodule

// File: r_router.sv
`timescale 1ns/1ps

module r_router (
  input  logic                              clk,
  input  logic                              rstn,
  input  axi_pkg::r_s_t                     s_r [addr_map_pkg::n_slaves],
  input  logic [addr_map_pkg::n_slaves-1:0] s_rvalid,
  output logic [addr_map_pkg::n_slaves-1:0] s_rready,
  output axi_pkg::r_m_t                     m0_r,
  output logic                              m0_rvalid,
  input  logic                              m0_rready,
  output axi_pkg::r_m_t                     m1_r,
  output logic                              m1_rvalid,
  input  logic                              m1_rready
);
  import axi_pkg::*;
  import addr_map_pkg::*;

  logic [1:0] m_rready;
  logic [1:0] m_rvalid;
  logic [1:0] busy_q;  // Route held mid burst
  logic [1:0] found;
  logic [1:0] done;
  logic [1:0] route_q [2];
  logic [1:0] route   [2];
  r_m_t       m_r     [2];

  assign m_rready = {m1_rready, m0_rready};

  always_comb begin
    for (int m = 0; m < 2; m++) begin
      found[m] = 1'b0;
      route[m] = route_q[m];
      if (!busy_q[m]) begin
        // Scan down so the lowest slave wins
        for (int i = n_slaves - 1; i >= 0; i--) begin
          if (s_rvalid[i] &&
              (s_r[i].id[axi_ids_bits-1] == ((m == 0) ? master_0_id : master_1_id))) begin
            found[m] = 1'b1;
            route[m] = 2'(i);
          end
        end
      end
      m_rvalid[m] = (busy_q[m] | found[m]) & s_rvalid[route[m]];
      m_r[m]      = '0;
      if (busy_q[m] | found[m]) begin
        m_r[m].id   = s_r[route[m]].id[axi_id_bits-1:0];  // Strip master tag
        m_r[m].data = s_r[route[m]].data;
        m_r[m].resp = s_r[route[m]].resp;
        m_r[m].last = s_r[route[m]].last;
      end
      done[m] = m_rvalid[m] & m_rready[m] & m_r[m].last;
    end
  end

  // Ready goes back to the routed slave only
  always_comb begin
    s_rready = '0;
    for (int m = 0; m < 2; m++) begin
      if (busy_q[m] | found[m]) begin
        s_rready[route[m]] = m_rready[m];
      end
    end
  end

  assign m0_r      = m_r[0];
  assign m0_rvalid = m_rvalid[0];
  assign m1_r      = m_r[1];
  assign m1_rvalid = m_rvalid[1];

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy_q <= '0;
      for (int m = 0; m < 2; m++) begin
        route_q[m] <= '0;
      end
    end else begin
      for (int m = 0; m < 2; m++) begin
        busy_q[m]  <= (busy_q[m] | found[m]) & ~done[m];
        route_q[m] <= route[m];
      end
    end
  end

endmodule

// File: rd_mem_slave.sv
`timescale 1ns/1ps

module rd_mem_slave #(
  parameter logic [7:0] slv_tag = 8'h00
) (
  input  logic           clk,
  input  logic           rstn,
  input  axi_pkg::ar_s_t ar,
  input  logic           arvalid,
  output logic           arready,
  output axi_pkg::r_s_t  r,
  output logic           rvalid,
  input  logic           rready
);
  import axi_pkg::*;

  logic                     busy_q;
  logic                     busy_d;
  logic                     ready_q;
  logic                     ar_hs;
  logic                     r_hs;
  logic                     last;
  logic [axi_ids_bits-1:0]  id_q;
  logic [axi_addr_bits-1:0] addr_q;  // Current beat address
  logic [axi_addr_bits-1:0] next_addr;
  logic [axi_len_bits-1:0]  cnt_q;   // Beats left after this one
  logic [axi_size_bits-1:0] size_q;
  logic [1:0]               burst_q;

  assign ar_hs   = arvalid & ready_q;
  assign r_hs    = busy_q & rready;
  assign last    = (cnt_q == '0);
  assign arready = ready_q;
  assign rvalid  = busy_q;

  assign r = '{
    id:   id_q,
    data: {slv_tag, addr_q[23:0]},
    resp: resp_okay,
    last: last
  };

  // WRAP is walked like INCR
  always_comb begin
    case (burst_q)
      burst_incr,
      burst_wrap: next_addr = addr_q + (axi_addr_bits'(1) << size_q);
      default:    next_addr = addr_q;  // burst_fixed
    endcase
  end

  always_comb begin
    busy_d = busy_q;
    if (ar_hs) begin
      busy_d = 1'b1;
    end else if (r_hs && last) begin
      busy_d = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy_q  <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      busy_q  <= busy_d;
      ready_q <= ~busy_d;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      id_q    <= ar.id;
      addr_q  <= ar.addr;
      cnt_q   <= ar.len;
      size_q  <= ar.size;
      burst_q <= ar.burst;
    end else if (r_hs) begin
      addr_q <= next_addr;
      cnt_q  <= cnt_q - 1'b1;
    end
  end

endmodule

// File: default_slave.sv
`timescale 1ns/1ps

module default_slave (
  input  logic           clk,
  input  logic           rstn,
  input  axi_pkg::ar_s_t ar,
  input  logic           arvalid,
  output logic           arready,
  output axi_pkg::r_s_t  r,
  output logic           rvalid,
  input  logic           rready
);
  import axi_pkg::*;

  logic                    busy_q;
  logic                    busy_d;
  logic                    ready_q;
  logic                    ar_hs;
  logic                    r_hs;
  logic                    last;
  logic [axi_ids_bits-1:0] id_q;
  logic [axi_len_bits-1:0] cnt_q;

  assign ar_hs   = arvalid & ready_q;
  assign r_hs    = busy_q & rready;
  assign last    = (cnt_q == '0);
  assign arready = ready_q;
  assign rvalid  = busy_q;

  assign r = '{id: id_q, data: '0, resp: resp_decerr, last: last};

  always_comb begin
    busy_d = busy_q;
    if (ar_hs) begin
      busy_d = 1'b1;
    end else if (r_hs && last) begin
      busy_d = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy_q  <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      busy_q  <= busy_d;
      ready_q <= ~busy_d;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      id_q  <= ar.id;
      cnt_q <= ar.len;
    end else if (r_hs) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

endmodule

// File: axi_rd_fabric.sv
`timescale 1ns/1ps

module axi_rd_fabric (
  input  logic           clk,
  input  logic           rstn,
  input  axi_pkg::ar_m_t m0_ar,
  input  logic           m0_arvalid,
  output logic           m0_arready,
  output axi_pkg::r_m_t  m0_r,
  output logic           m0_rvalid,
  input  logic           m0_rready,
  input  axi_pkg::ar_m_t m1_ar,
  input  logic           m1_arvalid,
  output logic           m1_arready,
  output axi_pkg::r_m_t  m1_r,
  output logic           m1_rvalid,
  input  logic           m1_rready
);
  import axi_pkg::*;
  import addr_map_pkg::*;

  localparam logic [7:0] tag_s0 = 8'ha0;
  localparam logic [7:0] tag_s1 = 8'hb1;

  ar_s_t               s_ar [n_slaves];
  r_s_t                s_r  [n_slaves];
  logic [n_slaves-1:0] s_arvalid;
  logic [n_slaves-1:0] s_arready;
  logic [n_slaves-1:0] s_rvalid;
  logic [n_slaves-1:0] s_rready;
  logic [n_slaves-1:0] s_rdone;
  logic                m0_rdone;
  logic                m1_rdone;

  // Last beat accepted, frees the router locks
  assign m0_rdone = m0_rvalid & m0_rready & m0_r.last;
  assign m1_rdone = m1_rvalid & m1_rready & m1_r.last;

  for (genvar i = 0; i < n_slaves; i++) begin : g_rdone
    assign s_rdone[i] = s_rvalid[i] & s_rready[i] & s_r[i].last;
  end

  ar_router u_ar_router (
    .clk        (clk),
    .rstn       (rstn),
    .m0_ar      (m0_ar),
    .m0_arvalid (m0_arvalid),
    .m0_arready (m0_arready),
    .m0_rdone   (m0_rdone),
    .m1_ar      (m1_ar),
    .m1_arvalid (m1_arvalid),
    .m1_arready (m1_arready),
    .m1_rdone   (m1_rdone),
    .s_ar       (s_ar),
    .s_arvalid  (s_arvalid),
    .s_arready  (s_arready),
    .s_rdone    (s_rdone)
  );

  r_router u_r_router (
    .clk       (clk),
    .rstn      (rstn),
    .s_r       (s_r),
    .s_rvalid  (s_rvalid),
    .s_rready  (s_rready),
    .m0_r      (m0_r),
    .m0_rvalid (m0_rvalid),
    .m0_rready (m0_rready),
    .m1_r      (m1_r),
    .m1_rvalid (m1_rvalid),
    .m1_rready (m1_rready)
  );

  rd_mem_slave #(
    .slv_tag (tag_s0)
  ) u_mem_s0 (
    .clk     (clk),
    .rstn    (rstn),
    .ar      (s_ar[slave_0]),
    .arvalid (s_arvalid[slave_0]),
    .arready (s_arready[slave_0]),
    .r       (s_r[slave_0]),
    .rvalid  (s_rvalid[slave_0]),
    .rready  (s_rready[slave_0])
  );

  rd_mem_slave #(
    .slv_tag (tag_s1)
  ) u_mem_s1 (
    .clk     (clk),
    .rstn    (rstn),
    .ar      (s_ar[slave_1]),
    .arvalid (s_arvalid[slave_1]),
    .arready (s_arready[slave_1]),
    .r       (s_r[slave_1]),
    .rvalid  (s_rvalid[slave_1]),
    .rready  (s_rready[slave_1])
  );

  default_slave u_def_slave (
    .clk     (clk),
    .rstn    (rstn),
    .ar      (s_ar[slave_def]),
    .arvalid (s_arvalid[slave_def]),
    .arready (s_arready[slave_def]),
    .r       (s_r[slave_def]),
    .rvalid  (s_rvalid[slave_def]),
    .rready  (s_rready[slave_def])
  );

endmodule

// File: tb_axi_rd_fabric.sv
`timescale 1ns/1ps

module tb_axi_rd_fabric;
  import axi_pkg::*;

  typedef struct packed {
    logic       msel;    // Master that owns the row
    logic [1:0] second;  // 0 none, 1 other master too, 2 same master again
    logic [31:0] addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
    logic       stall;   // Random rready
  } test_t;

  localparam int n_tests      = 9;
  localparam int reset_cycles = 10;
  localparam int max_cycles   = n_tests * 64 + reset_cycles;

  // Own copies of the slave tags and response codes
  localparam logic [7:0] tag_s0  = 8'ha0;
  localparam logic [7:0] tag_s1  = 8'hb1;
  localparam logic [1:0] rsp_ok  = 2'b00;
  localparam logic [1:0] rsp_dec = 2'b11;

  localparam test_t tests [n_tests] = '{
    '{1'b0, 2'd0, 32'h0000_1234, 8'd0, 3'd2, 2'b01, 1'b0},  // Single beat
    '{1'b1, 2'd0, 32'h1000_0040, 8'd7, 3'd2, 2'b01, 1'b0},  // INCR burst
    '{1'b0, 2'd0, 32'h2000_0000, 8'd3, 3'd2, 2'b01, 1'b0},  // Unmapped
    '{1'b1, 2'd1, 32'h0000_0100, 8'd3, 3'd2, 2'b01, 1'b0},  // Both masters
    '{1'b1, 2'd0, 32'h0000_0200, 8'd5, 3'd2, 2'b00, 1'b1},  // FIXED, stalls
    '{1'b0, 2'd0, 32'h1000_0300, 8'd7, 3'd1, 2'b01, 1'b1},  // INCR, stalls
    '{1'b1, 2'd2, 32'h0000_0400, 8'd3, 3'd2, 2'b01, 1'b1},  // Lock
    '{1'b0, 2'd0, 32'h1000_0010, 8'd3, 3'd2, 2'b10, 1'b0},  // WRAP as INCR
    '{1'b0, 2'd2, 32'h3000_0000, 8'd1, 3'd2, 2'b01, 1'b0}   // Lock on DECERR
  };

  logic       clk;
  logic       rstn;
  ar_m_t      m_ar [2];
  logic [1:0] m_arvalid;
  logic [1:0] m_arready;
  r_m_t       m_r [2];
  logic [1:0] m_rvalid;
  logic [1:0] m_rready;
  integer     seed;
  int         cyc = 0;
  int         errors;
  int         failed;

  axi_rd_fabric u_axi_rd_fabric (
    .clk        (clk),
    .rstn       (rstn),
    .m0_ar      (m_ar[0]),
    .m0_arvalid (m_arvalid[0]),
    .m0_arready (m_arready[0]),
    .m0_r       (m_r[0]),
    .m0_rvalid  (m_rvalid[0]),
    .m0_rready  (m_rready[0]),
    .m1_ar      (m_ar[1]),
    .m1_arvalid (m_arvalid[1]),
    .m1_arready (m_arready[1]),
    .m1_r       (m_r[1]),
    .m1_rvalid  (m_rvalid[1]),
    .m1_rready  (m_rready[1])
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  initial begin
    wait (cyc >= max_cycles);
    $display("Timeout: a test hung, no progress after %0d cycles", max_cycles);
    $display("Simulation failed");
    $finish;
  end

  // Expected beat from the address map and the data rule
  function automatic r_m_t expect_beat(input ar_m_t req, input int beat);
    r_m_t        exp;
    logic [31:0] baddr;
    logic [7:0]  tag;
    logic        mapped;
    mapped = 1'b1;
    tag    = 8'h00;
    if (req.addr[31:16] == 16'h0000) begin
      tag = tag_s0;
    end else if (req.addr[31:16] == 16'h1000) begin
      tag = tag_s1;
    end else begin
      mapped = 1'b0;
    end
    if (req.burst == 2'b00) begin
      baddr = req.addr;  // FIXED repeats the word
    end else begin
      baddr = req.addr + (32'(beat) << req.size);
    end
    exp.id   = req.id;
    exp.last = (beat == int'(req.len));
    exp.data = mapped ? {tag, baddr[23:0]} : 32'h0;
    exp.resp = mapped ? rsp_ok : rsp_dec;
    return exp;
  endfunction

  task automatic compare_field(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    assert (exp === got) else begin
      $display("** Error: %s expected %h got %h", name, exp, got);
      errors++;
    end
  endtask

  // Called and returns 1 ns after a rising edge
  task automatic send_ar(input int m, input ar_m_t req, output int hs_at);
    m_ar[m]      = req;
    m_arvalid[m] = 1'b1;
    @(negedge clk);
    while (!m_arready[m]) begin
      @(negedge clk);
    end
    hs_at = cyc;
    @(posedge clk);
    #1;
    m_arvalid[m] = 1'b0;
  endtask

  task automatic collect_burst(input int m, input ar_m_t req, input logic stall,
                               output int done_at);
    r_m_t        exp;
    logic [31:0] rnd;
    int          beat;
    logic        finished;
    beat     = 0;
    finished = 1'b0;
    while (!finished) begin
      rnd         = $random(seed);
      m_rready[m] = stall ? rnd[0] : 1'b1;
      @(negedge clk);
      if (m_rvalid[m] && m_rready[m]) begin
        exp = expect_beat(req, beat);
        compare_field($sformatf("m%0d_r.data", m), exp.data, m_r[m].data);
        compare_field($sformatf("m%0d_r.resp", m), 32'(exp.resp), 32'(m_r[m].resp));
        compare_field($sformatf("m%0d_r.id", m), 32'(exp.id), 32'(m_r[m].id));
        compare_field($sformatf("m%0d_r.last", m), 32'(exp.last), 32'(m_r[m].last));
        finished = m_r[m].last || (beat == int'(req.len));
        done_at  = cyc;
        beat++;
      end
      @(posedge clk);
      #1;
    end
    m_rready[m] = 1'b0;
  endtask

  task automatic run_test(input int t);
    test_t row;
    ar_m_t req_a;
    ar_m_t req_b;
    int    m;
    int    o;
    int    hs_a;
    int    hs_b;
    int    done_a;
    int    done_b;
    int    err_before;
    row        = tests[t];
    m          = int'(row.msel);
    o          = 1 - m;
    err_before = errors;
    req_a      = '{id: 4'(t), addr: row.addr, len: row.len, size: row.size, burst: row.burst};
    req_b      = req_a;
    case (row.second)
      2'd1: begin
        req_b.addr = req_a.addr ^ 32'h1000_0000;  // Other memory slave
        fork
          send_ar(m, req_a, hs_a);
          collect_burst(m, req_a, row.stall, done_a);
          send_ar(o, req_b, hs_b);
          collect_burst(o, req_b, row.stall, done_b);
        join
        assert ((m == 0) ? (hs_a < hs_b) : (hs_b < hs_a)) else begin
          $display("Master 1 address was accepted before master 0 in test %0d", t);
          errors++;
        end
      end
      2'd2: begin
        req_b.id   = req_a.id + 4'd1;
        req_b.addr = {16'h1000, req_a.addr[15:0] + 16'h20};  // Idle slave 1
        fork
          begin
            send_ar(m, req_a, hs_a);
            send_ar(m, req_b, hs_b);
          end
          begin
            collect_burst(m, req_a, row.stall, done_a);
            collect_burst(m, req_b, row.stall, done_b);
          end
        join
        assert (hs_b > done_a) else begin
          $display("Second read on master %0d was accepted before the first burst ended", m);
          errors++;
        end
      end
      default: begin
        fork
          send_ar(m, req_a, hs_a);
          collect_burst(m, req_a, row.stall, done_a);
        join
      end
    endcase
    if (errors != err_before) begin
      failed++;
    end
    $display("test %0d master %0d addr %h len %0d: %s", t, m, row.addr, row.len,
             (errors == err_before) ? "PASS" : "FAIL");
  endtask

  initial begin
    seed      = 32'h52df_28da;
    errors    = 0;
    failed    = 0;
    rstn      = 1'b0;
    m_ar[0]   = '0;
    m_ar[1]   = '0;
    m_arvalid = '0;
    m_rready  = '0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rstn = 1'b1;
    @(posedge clk);
    #1;
    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    $display("tests %0d, failed %0d, errors %0d", n_tests, failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: axi_rd_fabric.f
axi_pkg.sv
addr_map_pkg.sv
ar_router.sv
r_router.sv
rd_mem_slave.sv
default_slave.sv
axi_rd_fabric.sv
tb_axi_rd_fabric.sv

// File: run.sh
#!/bin/bash
# Build and run the read fabric testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axi_rd_fabric -f axi_rd_fabric.f -o sim_tb \
  && ./obj_dir/sim_tb | tee sim.log \
  && grep -q "Simulation completed successfully" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
